// File: logic/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// byte address width
// 13 bits reach 8 KiB of data memory
`define LSU_ADDR_W 13

// memory depth in bytes, must match 2**LSU_ADDR_W
`define LSU_MEM_BYTES 8192

// data word width
// the byte lane logic assumes four lanes
`define LSU_DATA_W 32

`endif

// File: logic/lsu_pkg.sv
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

   // access width carried with every request
   typedef enum logic [1:0] {
      size_byte = 2'd0,  // 8 bit access
      size_half = 2'd1,  // 16 bit access
      size_word = 2'd2   // full 32 bit access
   } access_size_e;

   // one read word from data_mem
   // load alignment picks either a byte lane or a halfword out of it
   typedef union packed {
      logic [`LSU_DATA_W-1:0]         raw;     // whole word as stored
      logic [`LSU_DATA_W/8-1:0][7:0]  bytes;   // bytes[0] is lane 0, lowest address
      logic [`LSU_DATA_W/16-1:0][15:0] halves; // halves[1] sits at offset 2
   } mem_word_u;

endpackage

`default_nettype wire

// File: logic/lsu_req_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_req_stage (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   input  wire                          req_valid_i,    // one strobe per request
   input  wire                          req_store_i,    // 1 = store, 0 = load
   input  wire lsu_pkg::access_size_e   req_size_i,
   input  wire                          req_unsigned_i, // zero extend on loads
   input  wire [`LSU_ADDR_W-1:0]        req_addr_i,     // byte address
   input  wire [`LSU_DATA_W-1:0]        req_wdata_i,    // store data, right aligned
   output logic                         mem_write_o,
   output logic [`LSU_DATA_W/8-1:0]     mem_be_o,
   output logic [`LSU_ADDR_W-1:0]       mem_addr_o,
   output logic [`LSU_DATA_W-1:0]       mem_wdata_o,
   output logic                         s2_load_o,
   output logic                         s2_store_o,
   output logic                         s2_misalign_o,
   output lsu_pkg::access_size_e        s2_size_o,
   output logic                         s2_unsigned_o,
   output logic [1:0]                   s2_offset_o
);

   import lsu_pkg::*;

   localparam int LANES = `LSU_DATA_W / 8; // byte lanes per word

   logic                   misalign;  // access crosses its natural boundary
   logic [LANES-1:0]       be;        // lanes touched by this access
   logic [`LSU_DATA_W-1:0] lane_data; // store data copied onto its lanes
   logic                   do_load;
   logic                   do_store;

   // alignment check
   always_comb begin
      case (req_size_i)
         size_half: misalign = req_addr_i[0];
         size_word: misalign = |req_addr_i[1:0];
         default:   misalign = 1'b0;        // bytes never misalign
      endcase
   end

   // byte enables and lane replication
   // the memory only takes the lanes that are enabled so copying is enough
   always_comb begin
      case (req_size_i)
         size_byte: begin
            be        = {{(LANES-1){1'b0}}, 1'b1} << req_addr_i[1:0];
            lane_data = {LANES{req_wdata_i[7:0]}};
         end
         size_half: begin
            be        = {{(LANES-2){1'b0}}, 2'b11} << {req_addr_i[1], 1'b0};
            lane_data = {(LANES/2){req_wdata_i[15:0]}};
         end
         default: begin
            be        = '1;                  // whole word
            lane_data = req_wdata_i;
         end
      endcase
   end

   assign do_load  = req_valid_i & ~req_store_i & ~misalign;
   assign do_store = req_valid_i & req_store_i & ~misalign;

   // stage 2 control, cleared on reset
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mem_write_o   <= 1'b0;
         s2_load_o     <= 1'b0;
         s2_store_o    <= 1'b0;
         s2_misalign_o <= 1'b0;
         s2_size_o     <= size_byte;
         s2_unsigned_o <= 1'b0;
         s2_offset_o   <= 2'b00;
      end else begin
         mem_write_o   <= do_store;          // a misaligned store never writes
         s2_load_o     <= do_load;
         s2_store_o    <= do_store;
         s2_misalign_o <= req_valid_i & misalign;
         s2_size_o     <= req_size_i;
         s2_unsigned_o <= req_unsigned_i;
         s2_offset_o   <= req_addr_i[1:0];   // lane select for the align stage
      end
   end

   // stage 2 payload
   always_ff @(posedge clk_i) begin
      mem_be_o    <= be;
      mem_addr_o  <= {req_addr_i[`LSU_ADDR_W-1:2], 2'b00}; // word address
      mem_wdata_o <= lane_data;
   end

endmodule

`default_nettype wire

// File: logic/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module data_mem (
   input  wire                       clk_i,
   input  wire                       write_i,   // commit the enabled lanes
   input  wire [`LSU_DATA_W/8-1:0]   be_sel_i,  // one enable per byte lane
   input  wire [`LSU_ADDR_W-1:0]     addr_i,    // byte address, low bits ignored
   input  wire [`LSU_DATA_W-1:0]     data_i,
   output logic [`LSU_DATA_W-1:0]    data_o
);

   localparam int LANES = `LSU_DATA_W / 8;

   logic [7:0]               mem [0:`LSU_MEM_BYTES-1]; // byte array, no reset
   logic [`LSU_ADDR_W-3:0]   word_addr;

   assign word_addr = addr_i[`LSU_ADDR_W-1:2];

   // combinational read of all four lanes of the addressed word
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         data_o[8*i +: 8] = mem[{word_addr, 2'(i)}];
      end
   end

   // masked write
   // lanes without their enable keep the old byte
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < LANES; i++) begin
         if (write_i && be_sel_i[i]) begin
            mem[{word_addr, 2'(i)}] <= data_i[8*i +: 8];
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/load_align_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module load_align_stage (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         s2_load_i,      // aligned load in stage 2
   input  wire                         s2_store_i,     // aligned store in stage 2
   input  wire                         s2_misalign_i,  // rejected access
   input  wire lsu_pkg::access_size_e  s2_size_i,
   input  wire                         s2_unsigned_i,
   input  wire [1:0]                   s2_offset_i,    // byte offset in the word
   input  wire [`LSU_DATA_W-1:0]       mem_rdata_i,    // comb read word from data_mem
   output logic                        load_valid_o,
   output logic [`LSU_DATA_W-1:0]      load_data_o,
   output logic                        store_done_o,
   output logic                        misalign_o
);

   import lsu_pkg::*;

   mem_word_u              rword;     // read word seen as bytes or halves
   logic [7:0]             sel_byte;
   logic [15:0]            sel_half;
   logic [`LSU_DATA_W-1:0] ext_data;  // extended load result
   logic                   sign_b;
   logic                   sign_h;

   assign rword = mem_rdata_i;

   assign sel_byte = rword.bytes[s2_offset_i];     // any offset
   assign sel_half = rword.halves[s2_offset_i[1]]; // offset 0 or 2

   // sign bits, forced low for unsigned loads
   assign sign_b = sel_byte[7] & ~s2_unsigned_i;
   assign sign_h = sel_half[15] & ~s2_unsigned_i;

   always_comb begin
      case (s2_size_i)
         size_byte: ext_data = {{(`LSU_DATA_W-8){sign_b}}, sel_byte};
         size_half: ext_data = {{(`LSU_DATA_W-16){sign_h}}, sel_half};
         default:   ext_data = rword.raw;               // word passes as is
      endcase
   end

   // response pulses
   // each is high for one cycle after the registering edge
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         load_valid_o <= 1'b0;
         store_done_o <= 1'b0;
         misalign_o   <= 1'b0;
      end else begin
         load_valid_o <= s2_load_i;      // already qualified by alignment
         store_done_o <= s2_store_i;
         misalign_o   <= s2_misalign_i;  // never together with the other two
      end
   end

   // load result, held until the next load
   always_ff @(posedge clk_i) begin
      if (s2_load_i) begin
         load_data_o <= ext_data;
      end
   end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_top (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         req_valid_i,
   input  wire                         req_store_i,
   input  wire lsu_pkg::access_size_e  req_size_i,
   input  wire                         req_unsigned_i,
   input  wire [`LSU_ADDR_W-1:0]       req_addr_i,
   input  wire [`LSU_DATA_W-1:0]       req_wdata_i,
   output logic                        load_valid_o,
   output logic [`LSU_DATA_W-1:0]      load_data_o,
   output logic                        store_done_o,
   output logic                        misalign_o
);

   import lsu_pkg::*;

   // stage 2 toward the memory
   logic                     mem_write;
   logic [`LSU_DATA_W/8-1:0] mem_be;
   logic [`LSU_ADDR_W-1:0]   mem_addr;
   logic [`LSU_DATA_W-1:0]   mem_wdata;
   logic [`LSU_DATA_W-1:0]   mem_rdata;   // comb read word

   // stage 2 toward load alignment
   logic                     s2_load;
   logic                     s2_store;
   logic                     s2_misalign;
   access_size_e             s2_size;
   logic                     s2_unsigned;
   logic [1:0]               s2_offset;

   // request register, alignment check and lane placement
   lsu_req_stage u_req (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .req_valid_i    (req_valid_i),
      .req_store_i    (req_store_i),
      .req_size_i     (req_size_i),
      .req_unsigned_i (req_unsigned_i),
      .req_addr_i     (req_addr_i),
      .req_wdata_i    (req_wdata_i),
      .mem_write_o    (mem_write),
      .mem_be_o       (mem_be),
      .mem_addr_o     (mem_addr),
      .mem_wdata_o    (mem_wdata),
      .s2_load_o      (s2_load),
      .s2_store_o     (s2_store),
      .s2_misalign_o  (s2_misalign),
      .s2_size_o      (s2_size),
      .s2_unsigned_o  (s2_unsigned),
      .s2_offset_o    (s2_offset)
   );

   // stores commit at the end of stage 2 and loads read during it
   data_mem u_mem (
      .clk_i    (clk_i),
      .write_i  (mem_write),
      .be_sel_i (mem_be),
      .addr_i   (mem_addr),
      .data_i   (mem_wdata),
      .data_o   (mem_rdata)
   );

   load_align_stage u_align (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .s2_load_i     (s2_load),
      .s2_store_i    (s2_store),
      .s2_misalign_i (s2_misalign),
      .s2_size_i     (s2_size),
      .s2_unsigned_i (s2_unsigned),
      .s2_offset_i   (s2_offset),
      .mem_rdata_i   (mem_rdata),
      .load_valid_o  (load_valid_o),
      .load_data_o   (load_data_o),
      .store_done_o  (store_done_o),
      .misalign_o    (misalign_o)
   );

endmodule

`default_nettype wire

// File: tests/lsu_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_checker (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         req_valid_i,
   input  wire                         req_store_i,
   input  wire lsu_pkg::access_size_e  req_size_i,
   input  wire                         req_unsigned_i,
   input  wire [`LSU_ADDR_W-1:0]       req_addr_i,
   input  wire [`LSU_DATA_W-1:0]       req_wdata_i,
   input  wire                         load_valid_i,
   input  wire [`LSU_DATA_W-1:0]       load_data_i,
   input  wire                         store_done_i,
   input  wire                         misalign_i,
   output int                          err_count_o,   // wrong values seen
   output int                          resp_count_o,  // response pulses seen
   output int                          check_count_o  // cycles compared
);

   import lsu_pkg::*;

   logic [7:0]             model_mem [0:`LSU_MEM_BYTES-1]; // reference byte array
   logic [`LSU_DATA_W+2:0] pend_q [$];  // {load, store, misalign, data}, two deep

   // natural boundary rule per access size
   function automatic logic is_misaligned(input access_size_e size,
                                          input logic [`LSU_ADDR_W-1:0] addr);
      case (size)
         size_half: return addr[0];
         size_word: return addr[1] | addr[0];
         default:   return 1'b0;
      endcase
   endfunction

   // load value from the model, extended as the size and flag say
   function automatic logic [`LSU_DATA_W-1:0] expect_load(input access_size_e size,
                                                          input logic uns,
                                                          input logic [`LSU_ADDR_W-1:0] addr);
      mem_word_u              w;
      logic [`LSU_ADDR_W-1:0] base;
      logic [7:0]             b;
      logic [15:0]            h;
      base = {addr[`LSU_ADDR_W-1:2], 2'b00};
      for (int i = 0; i < 4; i++) begin
         w.bytes[i] = model_mem[base + i];  // lane i is the byte at base + i
      end
      b = w.bytes[addr[1:0]];
      h = w.halves[addr[1]];
      case (size)
         size_byte: return uns ? {24'h0, b} : {{24{b[7]}}, b};
         size_half: return uns ? {16'h0, h} : {{16{h[15]}}, h};
         default:   return w.raw;
      endcase
   endfunction

   // right aligned store data goes to consecutive bytes, low byte first
   task automatic apply_store(input access_size_e size,
                              input logic [`LSU_ADDR_W-1:0] addr,
                              input logic [`LSU_DATA_W-1:0] wdata);
      int nbytes;
      nbytes = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
      for (int i = 0; i < nbytes; i++) begin
         model_mem[addr + i] = wdata[8*i +: 8];
      end
   endtask

   task automatic compare_value(input string name, input logic [`LSU_DATA_W-1:0] exp,
                                input logic [`LSU_DATA_W-1:0] got);
      if (got !== exp) begin
         $display("ERR %s expected %h got %h at %0t", name, exp, got, $time);
         err_count_o++;
      end
   endtask

   initial begin
      err_count_o   = 0;
      resp_count_o  = 0;
      check_count_o = 0;
   end

   // inputs read here are what the DUT samples at this edge
   // outputs read here were registered at the previous edge
   always @(posedge clk_i) begin
      logic [`LSU_DATA_W+2:0] ent;
      logic                   mis;
      logic                   ld;
      logic                   st;
      logic [`LSU_DATA_W-1:0] data;
      if (!rst_n_i) begin
         pend_q.delete();
         pend_q.push_back('0);  // outputs must stay low for the first two edges
         pend_q.push_back('0);
      end else begin
         if (pend_q.size() >= 2) begin
            ent = pend_q.pop_front();  // request from two edges back
            compare_value("load_valid_o", {31'h0, ent[`LSU_DATA_W+2]}, {31'h0, load_valid_i});
            compare_value("store_done_o", {31'h0, ent[`LSU_DATA_W+1]}, {31'h0, store_done_i});
            compare_value("misalign_o", {31'h0, ent[`LSU_DATA_W]}, {31'h0, misalign_i});
            if (ent[`LSU_DATA_W+2]) begin
               compare_value("load_data_o", ent[`LSU_DATA_W-1:0], load_data_i);
            end
            check_count_o++;
         end
         if (load_valid_i === 1'b1 || store_done_i === 1'b1 || misalign_i === 1'b1) begin
            resp_count_o++;
         end
         mis  = req_valid_i && is_misaligned(req_size_i, req_addr_i);
         ld   = req_valid_i && !req_store_i && !mis;
         st   = req_valid_i && req_store_i && !mis;
         data = ld ? expect_load(req_size_i, req_unsigned_i, req_addr_i) : '0;
         if (st) begin
            apply_store(req_size_i, req_addr_i, req_wdata_i);  // in request order
         end
         pend_q.push_back({ld, st, mis, data});
      end
   end

endmodule

`default_nettype wire

// File: tests/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_tb;

   import lsu_pkg::*;

   localparam int CLK_HALF   = 20;   // 40 ns period
   localparam int WAIT_LIMIT = 300;  // cycles before a wait gives up
   localparam int RAND_REQS  = 400;

   logic                   clk;
   logic                   rst_n;
   logic                   req_valid;
   logic                   req_store;
   access_size_e           req_size;
   logic                   req_unsigned;
   logic [`LSU_ADDR_W-1:0] req_addr;
   logic [`LSU_DATA_W-1:0] req_wdata;
   logic                   load_valid;
   logic [`LSU_DATA_W-1:0] load_data;
   logic                   store_done;
   logic                   misalign;
   int                     err_count;
   int                     resp_count;
   int                     check_count;
   int                     issued;      // requests sent so far
   int                     tb_errors;
   int                     err_base;    // error total at the start of a test
   logic [31:0]            lfsr_state;

   lsu_top UUT (
      .clk_i (clk), .rst_n_i (rst_n),
      .req_valid_i (req_valid), .req_store_i (req_store), .req_size_i (req_size),
      .req_unsigned_i (req_unsigned), .req_addr_i (req_addr), .req_wdata_i (req_wdata),
      .load_valid_o (load_valid), .load_data_o (load_data),
      .store_done_o (store_done), .misalign_o (misalign)
   );

   lsu_checker u_checker (
      .clk_i (clk), .rst_n_i (rst_n),
      .req_valid_i (req_valid), .req_store_i (req_store), .req_size_i (req_size),
      .req_unsigned_i (req_unsigned), .req_addr_i (req_addr), .req_wdata_i (req_wdata),
      .load_valid_i (load_valid), .load_data_i (load_data),
      .store_done_i (store_done), .misalign_i (misalign),
      .err_count_o (err_count), .resp_count_o (resp_count), .check_count_o (check_count)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // taps of x^32 + x^22 + x^2 + x + 1
   // one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r          = {r[30:0], fb};
      end
      return r;
   endfunction

   // initial memory contents
   // every address bit shows up in the word
   function automatic logic [31:0] fill_word(input logic [`LSU_ADDR_W-1:0] a);
      return {3'b101, a, 3'b011, ~a};
   endfunction

   task automatic issue(input logic store, input access_size_e size, input logic uns,
                        input logic [`LSU_ADDR_W-1:0] addr, input logic [31:0] wdata);
      @(posedge clk);
      req_valid    <= 1'b1;
      req_store    <= store;
      req_size     <= size;
      req_unsigned <= uns;
      req_addr     <= addr;
      req_wdata    <= wdata;
      issued++;
   endtask

   task automatic go_idle(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   // stop requesting and wait until every request has answered
   task automatic drain();
      int spins;
      go_idle(1);
      spins = 0;
      while (resp_count != issued && spins < WAIT_LIMIT) begin
         @(negedge clk);  // counters settle before the falling edge
         spins++;
      end
      if (resp_count != issued) begin
         $display("timeout: only %0d of %0d requests answered", resp_count, issued);
         $display("*** FAILED ***");
         $finish;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %s: %0d errors, %0d requests so far", name,
               err_count + tb_errors - err_base, issued);
      err_base = err_count + tb_errors;
   endtask

   // every narrow load of one word in both signednesses and then the word itself
   task automatic load_all_offsets(input logic [`LSU_ADDR_W-1:0] base);
      for (int u = 0; u < 2; u++) begin
         for (int off = 0; off < 4; off++) begin
            issue(1'b0, size_byte, u[0], base + off, '0);
         end
         issue(1'b0, size_half, u[0], base, '0);
         issue(1'b0, size_half, u[0], base + 2, '0);
      end
      issue(1'b0, size_word, 1'b0, base, '0);
   endtask

   initial begin
      logic                   prev_store;
      logic [`LSU_ADDR_W-1:0] prev_addr;
      logic                   store;
      logic [1:0]             sz_bits;
      logic                   uns;
      logic [`LSU_ADDR_W-1:0] addr;
      logic [31:0]            wdata;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req_store    = 1'b0;
      req_size     = size_byte;
      req_unsigned = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      issued       = 0;
      tb_errors    = 0;
      err_base     = 0;
      lfsr_state   = 32'h171f7c90;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      go_idle(8);  // nothing requested so nothing may answer
      @(negedge clk);
      if (resp_count != 0) begin
         $display("a response pulse rose although no request was sent");
         tb_errors++;
      end
      end_test("1 idle after reset");

      for (int w = 0; w < `LSU_MEM_BYTES / 4; w++) begin  // known contents everywhere
         issue(1'b1, size_word, 1'b0, 13'(w * 4), fill_word(13'(w * 4)));
      end
      drain();
      end_test("memory fill");

      for (int off = 0; off < 4; off++) begin  // each store followed by a word load
         issue(1'b1, size_byte, 1'b0, 13'h100 + off, take_bits(32));
         issue(1'b0, size_word, 1'b0, 13'h100, '0);
      end
      for (int off = 0; off < 4; off += 2) begin
         issue(1'b1, size_half, 1'b0, 13'h100 + off, take_bits(32));
         issue(1'b0, size_word, 1'b0, 13'h100, '0);
      end
      issue(1'b1, size_word, 1'b0, 13'h100, take_bits(32));
      issue(1'b0, size_word, 1'b0, 13'h100, '0);
      drain();
      end_test("2 store merge");

      // the two words give every lane and both halves each sign
      issue(1'b1, size_word, 1'b0, 13'h200, 32'h8a7f_f501);
      issue(1'b1, size_word, 1'b0, 13'h204, 32'h758a_0afe);
      load_all_offsets(13'h200);
      load_all_offsets(13'h204);
      for (int k = 0; k < 4; k++) begin
         load_all_offsets({11'(take_bits(11)), 2'b00});
      end
      drain();
      end_test("3 narrow loads");

      for (int off = 1; off < 4; off += 2) begin
         issue(1'b1, size_half, 1'b0, 13'h300 + off, take_bits(32));
         issue(1'b0, size_half, 1'b0, 13'h300 + off, '0);
      end
      for (int off = 1; off < 4; off++) begin
         issue(1'b1, size_word, 1'b0, 13'h300 + off, take_bits(32));
         issue(1'b0, size_word, 1'b0, 13'h300 + off, '0);
      end
      issue(1'b0, size_word, 1'b0, 13'h300, '0);  // still the fill value
      drain();
      end_test("4 misaligned");

      prev_store = 1'b0;
      prev_addr  = '0;
      for (int n = 0; n < RAND_REQS; n++) begin
         store   = take_bits(1);
         sz_bits = take_bits(2);
         if (sz_bits == 2'd3) sz_bits = 2'd2;  // no fourth size
         uns     = take_bits(1);
         addr    = take_bits(`LSU_ADDR_W);
         wdata   = take_bits(32);
         if (prev_store && take_bits(2) == 2'd0) begin  // load right behind a store
            store = 1'b0;
            addr  = prev_addr;
         end
         issue(store, access_size_e'(sz_bits), uns, addr, wdata);
         prev_store = store;
         prev_addr  = addr;
      end
      drain();
      end_test("5 random stream");

      go_idle(2);
      $display("checks %0d, checker errors %0d, testbench errors %0d",
               check_count, err_count, tb_errors);
      if (err_count == 0 && tb_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_req_stage.sv
logic/data_mem.sv
logic/load_align_stage.sv
logic/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv
